// File: build.f
src/l2_cache_pkg.sv
src/l2_cache_arb.sv
src/l2_cache_tag.sv
src/l2_cache_data.sv
src/l2_cache_ctrl.sv
src/l2_mem_port.sv
src/l2_perf_counters.sv
src/l2_cache.sv
tests/tb_clock.sv
tests/l2_cache_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build the L2 cache testbench with Verilator and run it"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --assert --timing -Wno-fatal -j 0 --top-module l2_cache_tb -f build.f
	-./obj_dir/Vl2_cache_tb > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: tests/l2_cache_tb.sv
// Random two-core traffic testbench for the L2 cache with memory, arbiter and cache models
`timescale 1ns/1ps

module l2_cache_tb;
	localparam int num_addrs = 40; // Three tags on sets 0 to 7 and two on the rest
	localparam int max_rsps = 600;
	localparam int stall_limit = 3000; // Cycles allowed between two responses

	logic clk;
	logic arst_n;
	logic [1:0] req_valid;
	l2_cache_pkg::l2_req_t req [2];
	logic [1:0] req_ready;
	logic rsp_valid;
	l2_cache_pkg::l2_rsp_t rsp;
	logic rsp_ready;
	logic mem_cmd_valid;
	l2_cache_pkg::mem_cmd_t mem_cmd;
	logic mem_cmd_ready;
	logic mem_wdata_valid;
	l2_cache_pkg::beat_t mem_wdata;
	logic mem_wdata_ready;
	logic mem_rdata_valid;
	l2_cache_pkg::beat_t mem_rdata;
	logic mem_rdata_ready;
	l2_cache_pkg::perf_count_t perf_hits;
	l2_cache_pkg::perf_count_t perf_misses;
	l2_cache_pkg::perf_count_t perf_writebacks;

	logic [31:0] rng;
	logic m_valid [16][2]; // Cache model
	logic m_dirty [16][2];
	l2_cache_pkg::l2_tag_t m_tag [16][2];
	logic m_lru [16]; // Way to evict next
	l2_cache_pkg::cache_line_t shadow [l2_cache_pkg::line_addr_t]; // Latest stored lines
	l2_cache_pkg::cache_line_t mem_lines [l2_cache_pkg::line_addr_t]; // Written back lines
	logic prio; // Arbiter model pointer
	logic [1:0] taken; // Core request accepted at the last edge
	logic busy; // Request in flight
	l2_cache_pkg::l2_rsp_t exp_rsp;
	logic exp_hit;
	logic exp_wb;
	l2_cache_pkg::line_addr_t wb_addr;
	l2_cache_pkg::cache_line_t wb_line;
	logic wb_cmd_seen;
	logic fill_cmd_seen;
	logic rsp_seen;
	int wb_beats;
	int rd_left; // Fill beats still to hand over
	logic rd_taken;
	l2_cache_pkg::cache_line_t rd_line;
	int cyc;
	int t_accept;
	int age;
	int rsp_count;
	int hits;
	int misses;
	int wbs;

	tb_clock u_clock (.clk(clk));
	l2_cache u_l2_cache (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Initial memory content where each beat mixes the whole address
	function automatic l2_cache_pkg::cache_line_t init_line(input l2_cache_pkg::line_addr_t a);
		logic [31:0] h;
		l2_cache_pkg::cache_line_t l;
		h = {20'hc3a5e, a};
		for (int b = 0; b < 4; b++) begin
			h = xorshift(h + {a, 20'(b)} + 32'h9e37_79b9);
			l[b*32 +: 32] = h;
		end
		return l;
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1, "l2_cache_tb stopped at its first error");
	endtask

	// Compares values up to the width of a whole response
	task automatic check_equal(input string name, input logic [159:0] got,
			input logic [159:0] exp);
		assert (got === exp) else
			abort_run($sformatf("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp));
	endtask

	// Predicts the whole request at acceptance since only one is in flight
	task automatic accept_request(input logic core, input l2_cache_pkg::l2_req_t r);
		l2_cache_pkg::l2_set_idx_t s;
		l2_cache_pkg::l2_tag_t t;
		logic way;
		s = r.addr[3:0];
		t = r.addr[11:4];
		assert (!busy) else abort_run("a second request was accepted while one was in flight");
		exp_rsp.core = core;
		exp_rsp.is_store = r.is_store;
		exp_rsp.addr = r.addr;
		if (r.is_store)
			exp_rsp.data = r.data; // Echo
		else
			exp_rsp.data = shadow.exists(r.addr) ? shadow[r.addr] : init_line(r.addr);
		exp_hit = 1'b0;
		exp_wb = 1'b0;
		way = 1'b0;
		for (int w = 0; w < 2; w++)
			if (m_valid[s][w] && m_tag[s][w] == t) begin
				exp_hit = 1'b1;
				way = w[0];
			end
		if (exp_hit) begin
			hits++;
			if (r.is_store)
				m_dirty[s][way] = 1'b1;
		end else begin
			misses++;
			way = m_lru[s];
			for (int w = 1; w >= 0; w--)
				if (!m_valid[s][w])
					way = w[0]; // Lowest free way first
			exp_wb = m_valid[s][way] && m_dirty[s][way];
			wb_addr = {m_tag[s][way], s};
			if (exp_wb) begin
				wbs++;
				wb_line = shadow[wb_addr]; // Dirty line holds its latest store
			end
			m_valid[s][way] = 1'b1;
			m_tag[s][way] = t;
			m_dirty[s][way] = r.is_store;
		end
		m_lru[s] = !way; // Touched or installed way is most recent
		if (r.is_store)
			shadow[r.addr] = r.data;
		busy = 1'b1;
		wb_cmd_seen = 1'b0;
		fill_cmd_seen = 1'b0;
		rsp_seen = 1'b0;
		wb_beats = 0;
		t_accept = cyc;
	endtask

	// Values from just before the rising edge
	task automatic sample_edge();
		logic win;
		cyc++;
		assert (!busy || req_ready == 2'b00) else
			abort_run("req_ready was high while a request was in flight");
		if (busy && rsp_valid && !rsp_seen) begin
			rsp_seen = 1'b1;
			if (exp_hit)
				check_equal("hit latency", 160'(cyc - t_accept), 160'd3);
		end
		if (rsp_valid && rsp_ready) begin
			assert (busy) else abort_run("a response arrived with no request in flight");
			check_equal("rsp", rsp, exp_rsp);
			assert (!exp_wb || wb_beats == 4) else
				abort_run("the response came before the writeback ended");
			assert (exp_hit || (fill_cmd_seen && rd_left == 0)) else
				abort_run("the response came before the fill ended");
			busy = 1'b0;
			rsp_count++;
			age = 0;
		end
		if (mem_cmd_valid && mem_cmd_ready) begin
			if (mem_cmd.is_write) begin
				assert (busy && exp_wb && !wb_cmd_seen) else
					abort_run("a write command came without a dirty victim");
				check_equal("mem_cmd.addr", mem_cmd.addr, wb_addr);
				wb_cmd_seen = 1'b1;
			end else begin
				assert (busy && !exp_hit && !fill_cmd_seen && (!exp_wb || wb_beats == 4)) else
					abort_run("a read command came without a predicted miss");
				check_equal("mem_cmd.addr", mem_cmd.addr, exp_rsp.addr);
				fill_cmd_seen = 1'b1;
				if (mem_lines.exists(mem_cmd.addr))
					rd_line = mem_lines[mem_cmd.addr];
				else
					rd_line = init_line(mem_cmd.addr);
				rd_left = 4;
			end
		end
		if (mem_wdata_valid && mem_wdata_ready) begin
			assert (wb_cmd_seen && wb_beats < 4) else
				abort_run("a write beat came outside a writeback");
			check_equal("mem_wdata", mem_wdata, wb_line[wb_beats*32 +: 32]);
			wb_beats++;
			if (wb_beats == 4)
				mem_lines[wb_addr] = wb_line; // Memory now holds the victim
		end
		rd_taken = mem_rdata_valid && mem_rdata_ready;
		if (rd_taken)
			rd_left--;
		if (|(req_valid & req_ready)) begin
			win = req_valid[prio] ? prio : !prio; // Favored core when both wait
			check_equal("req_ready", req_ready, 2'b01 << win);
			prio = !win;
			taken[win] = 1'b1;
			accept_request(win, req[win]);
		end
	endtask

	// Stimulus just after the falling edge
	task automatic drive_edge();
		int idx;
		for (int c = 0; c < 2; c++) begin
			if (taken[c]) begin
				req_valid[c] = 1'b0;
				taken[c] = 1'b0;
			end
			rng = xorshift(rng);
			if (!req_valid[c] && rng[2:0] < 3'd3) begin
				idx = int'(rng[31:8] % num_addrs);
				req[c].is_store = rng[3];
				req[c].addr = {8'(idx / 16 * 53 + 16), 4'(idx % 16)};
				for (int b = 0; b < 4; b++) begin
					rng = xorshift(rng);
					req[c].data[b*32 +: 32] = rng;
				end
				req_valid[c] = 1'b1; // Held until taken
			end
		end
		rng = xorshift(rng);
		rsp_ready = rng[1:0] != 2'b00; // Mostly ready
		mem_cmd_ready = rng[2];
		mem_wdata_ready = rng[4:3] != 2'b00;
		if (rd_taken)
			mem_rdata_valid = 1'b0;
		if (!mem_rdata_valid && rd_left > 0 && rng[6:5] != 2'b00) begin
			mem_rdata_valid = 1'b1;
			mem_rdata = rd_line[(4 - rd_left)*32 +: 32]; // Beat 0 first
		end
	endtask

	initial begin
		rng = 32'h5f69_7016;
		arst_n = 1'b0;
		req_valid = '0;
		req[0] = '0;
		req[1] = '0;
		rsp_ready = 1'b0;
		mem_cmd_ready = 1'b0;
		mem_wdata_ready = 1'b0;
		mem_rdata_valid = 1'b0;
		mem_rdata = '0;
		prio = 1'b0;
		taken = '0;
		busy = 1'b0;
		rd_left = 0;
		rd_taken = 1'b0;
		cyc = 0;
		age = 0;
		rsp_count = 0;
		hits = 0;
		misses = 0;
		wbs = 0;
		for (int s = 0; s < 16; s++) begin
			m_lru[s] = 1'b0;
			for (int w = 0; w < 2; w++) begin
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
				m_tag[s][w] = '0;
			end
		end
		repeat (8) @(posedge clk); // Reset held for 8 cycles
		@(negedge clk);
		arst_n = 1'b1;
		while (rsp_count < max_rsps) begin
			@(posedge clk);
			sample_edge();
			@(negedge clk);
			drive_edge();
			age++;
			assert (age < stall_limit) else
				abort_run("timeout while waiting for the next response");
		end
		check_equal("perf_hits", perf_hits, 160'(hits));
		check_equal("perf_misses", perf_misses, 160'(misses));
		check_equal("perf_writebacks", perf_writebacks, 160'(wbs));
		$display("TEST PASS");
		$finish;
	end
endmodule

// File: tests/tb_clock.sv
// Testbench clock source, free running with a 100 ns period
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // Half period
	end
endmodule

// File: src/l2_cache.sv
// Shared two-core L2 cache top level joining arbiter, controller, arrays and memory port
`timescale 1ns/1ps

module l2_cache (
	input logic clk,
	input logic arst_n,
	input logic [l2_cache_pkg::num_cores-1:0] req_valid,
	input l2_cache_pkg::l2_req_t req [l2_cache_pkg::num_cores],
	output logic [l2_cache_pkg::num_cores-1:0] req_ready,
	output logic rsp_valid,
	output l2_cache_pkg::l2_rsp_t rsp,
	input logic rsp_ready,
	output logic mem_cmd_valid,
	output l2_cache_pkg::mem_cmd_t mem_cmd,
	input logic mem_cmd_ready,
	output logic mem_wdata_valid,
	output l2_cache_pkg::beat_t mem_wdata,
	input logic mem_wdata_ready,
	input logic mem_rdata_valid,
	input l2_cache_pkg::beat_t mem_rdata,
	output logic mem_rdata_ready,
	output l2_cache_pkg::perf_count_t perf_hits,
	output l2_cache_pkg::perf_count_t perf_misses,
	output l2_cache_pkg::perf_count_t perf_writebacks
);
	// Arbiter to controller
	logic grant_valid;
	logic grant_take;
	l2_cache_pkg::l2_req_t grant;
	l2_cache_pkg::core_id_t grant_core;
	// Tag store strobes and results
	logic lookup_en;
	l2_cache_pkg::line_addr_t lookup_addr;
	logic hit;
	logic victim_dirty;
	l2_cache_pkg::l2_way_idx_t hit_way;
	l2_cache_pkg::l2_way_idx_t victim_way;
	l2_cache_pkg::l2_tag_t victim_tag;
	logic install_en;
	logic install_dirty;
	logic touch_en;
	logic mark_dirty_en;
	l2_cache_pkg::l2_way_idx_t install_way;
	l2_cache_pkg::l2_way_idx_t touch_way;
	// Data array
	logic data_rd_en;
	logic data_wr_en;
	l2_cache_pkg::l2_set_idx_t data_set;
	l2_cache_pkg::l2_way_idx_t data_way;
	l2_cache_pkg::cache_line_t data_wdata;
	l2_cache_pkg::cache_line_t data_rdata;
	// Memory port control
	logic mp_start;
	logic mp_is_write;
	logic mp_done;
	l2_cache_pkg::line_addr_t mp_addr;
	l2_cache_pkg::cache_line_t mp_wline;
	l2_cache_pkg::cache_line_t mp_rline;
	logic ev_hit;
	logic ev_miss;
	logic ev_wb;

	l2_cache_arb u_arb (.*);
	l2_cache_ctrl u_ctrl (.*);
	l2_cache_tag u_tag (.*);
	l2_cache_data u_data (
		.clk,
		.rd_en(data_rd_en),
		.wr_en(data_wr_en),
		.set(data_set),
		.way(data_way),
		.wdata(data_wdata),
		.rdata(data_rdata)
	);
	l2_mem_port u_mem_port (
		.*,
		.start(mp_start),
		.is_write(mp_is_write),
		.addr(mp_addr),
		.wline(mp_wline),
		.done(mp_done),
		.rline(mp_rline)
	);
	l2_perf_counters u_perf (.*);
endmodule

// File: src/l2_perf_counters.sv
// Saturating hit, miss and writeback event counters of the L2 cache
`timescale 1ns/1ps

module l2_perf_counters (
	input logic clk,
	input logic arst_n,
	input logic ev_hit,
	input logic ev_miss,
	input logic ev_wb,
	output l2_cache_pkg::perf_count_t perf_hits,
	output l2_cache_pkg::perf_count_t perf_misses,
	output l2_cache_pkg::perf_count_t perf_writebacks
);
	logic [2:0] ev;
	l2_cache_pkg::perf_count_t cnt [3];

	assign ev = {ev_wb, ev_miss, ev_hit};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 3; i++)
				cnt[i] <= '0;
		end else begin
			for (int i = 0; i < 3; i++)
				if (ev[i] && cnt[i] != '1)
					cnt[i] <= cnt[i] + 1'b1; // Sticks at all ones
		end
	end

	assign perf_hits = cnt[0];
	assign perf_misses = cnt[1];
	assign perf_writebacks = cnt[2];
endmodule

// File: src/l2_mem_port.sv
// Memory port of the L2 cache that moves lines as four beats over a valid/ready bus
`timescale 1ns/1ps

module l2_mem_port (
	input logic clk,
	input logic arst_n,
	input logic start,
	input logic is_write,
	input l2_cache_pkg::line_addr_t addr,
	input l2_cache_pkg::cache_line_t wline,
	output logic done,
	output l2_cache_pkg::cache_line_t rline,
	output logic mem_cmd_valid,
	output l2_cache_pkg::mem_cmd_t mem_cmd,
	input logic mem_cmd_ready,
	output logic mem_wdata_valid,
	output l2_cache_pkg::beat_t mem_wdata,
	input logic mem_wdata_ready,
	input logic mem_rdata_valid,
	input l2_cache_pkg::beat_t mem_rdata,
	output logic mem_rdata_ready
);
	logic [$clog2(l2_cache_pkg::beats_per_line)-1:0] beat_cnt;
	logic xfer; // Beat phase after the command is taken
	logic beat_fire;
	l2_cache_pkg::cache_line_t shift; // Outgoing or incoming line

	assign mem_wdata_valid = xfer && mem_cmd.is_write;
	assign mem_rdata_ready = xfer && !mem_cmd.is_write;
	assign mem_wdata = shift[l2_cache_pkg::beat_width-1:0]; // Beat 0 leaves first
	assign beat_fire = (mem_wdata_valid && mem_wdata_ready) ||
		(mem_rdata_valid && mem_rdata_ready);
	assign done = beat_fire && beat_cnt == $bits(beat_cnt)'(l2_cache_pkg::beats_per_line - 1);
	assign rline = shift; // Complete once done has pulsed

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_cmd_valid <= 1'b0;
			xfer <= 1'b0;
			beat_cnt <= '0;
		end else begin
			if (start)
				mem_cmd_valid <= 1'b1;
			if (mem_cmd_valid && mem_cmd_ready) begin
				mem_cmd_valid <= 1'b0;
				xfer <= 1'b1;
			end
			if (beat_fire)
				beat_cnt <= beat_cnt + 1'b1; // Wraps to zero after last beat
			if (done)
				xfer <= 1'b0;
		end
	end

	// Both directions shift right so beat 0 ends up in the low bits
	always_ff @(posedge clk) begin
		if (start) begin
			mem_cmd.is_write <= is_write;
			mem_cmd.addr <= addr;
			shift <= wline;
		end else if (beat_fire) begin
			shift <= {mem_rdata, shift[$bits(shift)-1:l2_cache_pkg::beat_width]};
		end
	end

	a_start_idle: assert property (@(posedge clk) disable iff (!arst_n)
		start |-> !mem_cmd_valid && !xfer);
endmodule

// File: src/l2_cache_ctrl.sv
// L2 cache controller FSM handling lookup, writeback, fill, install and response
`timescale 1ns/1ps

module l2_cache_ctrl (
	input logic clk,
	input logic arst_n,
	input logic grant_valid,
	input l2_cache_pkg::l2_req_t grant,
	input l2_cache_pkg::core_id_t grant_core,
	output logic grant_take,
	output logic lookup_en,
	output l2_cache_pkg::line_addr_t lookup_addr,
	input logic hit,
	input l2_cache_pkg::l2_way_idx_t hit_way,
	input l2_cache_pkg::l2_way_idx_t victim_way,
	input logic victim_dirty,
	input l2_cache_pkg::l2_tag_t victim_tag,
	output logic install_en,
	output l2_cache_pkg::l2_way_idx_t install_way,
	output logic install_dirty,
	output logic touch_en,
	output l2_cache_pkg::l2_way_idx_t touch_way,
	output logic mark_dirty_en,
	output logic data_rd_en,
	output logic data_wr_en,
	output l2_cache_pkg::l2_set_idx_t data_set,
	output l2_cache_pkg::l2_way_idx_t data_way,
	output l2_cache_pkg::cache_line_t data_wdata,
	input l2_cache_pkg::cache_line_t data_rdata,
	output logic mp_start,
	output logic mp_is_write,
	output l2_cache_pkg::line_addr_t mp_addr,
	output l2_cache_pkg::cache_line_t mp_wline,
	input logic mp_done,
	input l2_cache_pkg::cache_line_t mp_rline,
	output logic ev_hit,
	output logic ev_miss,
	output logic ev_wb,
	output logic rsp_valid,
	output l2_cache_pkg::l2_rsp_t rsp,
	input logic rsp_ready
);
	l2_cache_pkg::ctrl_state_t state;
	l2_cache_pkg::l2_req_t req_q; // Request in flight
	l2_cache_pkg::core_id_t core_q;
	logic miss_q; // Load data comes from the fill line

	assign grant_take = state == l2_cache_pkg::idle;
	assign lookup_en = grant_valid && grant_take; // Acceptance also starts the lookup
	assign lookup_addr = grant.addr;
	assign data_set = req_q.addr[l2_cache_pkg::set_bits-1:0];
	assign data_wdata = req_q.is_store ? req_q.data : mp_rline; // Store replaces whole line
	assign install_way = victim_way; // Tag store is untouched until install
	assign install_dirty = req_q.is_store;
	assign mp_is_write = state == l2_cache_pkg::wb_cmd;
	assign mp_addr = mp_is_write ? {victim_tag, data_set} : req_q.addr;
	assign mp_wline = data_rdata; // Victim read issued during lookup

	always_comb begin
		data_rd_en = 1'b0;
		data_wr_en = 1'b0;
		data_way = hit_way;
		touch_en = 1'b0;
		touch_way = hit_way;
		mark_dirty_en = 1'b0;
		install_en = 1'b0;
		mp_start = 1'b0;
		ev_hit = 1'b0;
		ev_miss = 1'b0;
		ev_wb = 1'b0;
		case (state)
			l2_cache_pkg::lookup: begin
				ev_hit = hit;
				ev_miss = !hit;
				if (hit) begin
					data_rd_en = !req_q.is_store;
					data_wr_en = req_q.is_store;
					mark_dirty_en = req_q.is_store;
					touch_en = 1'b1;
				end else if (victim_dirty) begin
					data_rd_en = 1'b1; // Fetch victim for writeback
					data_way = victim_way;
				end
			end
			l2_cache_pkg::wb_cmd,
			l2_cache_pkg::fill_cmd: mp_start = 1'b1;
			l2_cache_pkg::wb_wait: ev_wb = mp_done;
			l2_cache_pkg::install: begin
				data_wr_en = 1'b1;
				data_way = victim_way;
				install_en = 1'b1;
				touch_en = 1'b1;
				touch_way = victim_way; // New line is most recent
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= l2_cache_pkg::idle;
			rsp_valid <= 1'b0;
		end else begin
			case (state)
				l2_cache_pkg::idle: if (grant_valid) state <= l2_cache_pkg::lookup;
				l2_cache_pkg::lookup:
					if (hit)
						state <= l2_cache_pkg::respond;
					else if (victim_dirty)
						state <= l2_cache_pkg::wb_cmd;
					else
						state <= l2_cache_pkg::fill_cmd;
				l2_cache_pkg::wb_cmd: state <= l2_cache_pkg::wb_wait;
				l2_cache_pkg::wb_wait: if (mp_done) state <= l2_cache_pkg::fill_cmd;
				l2_cache_pkg::fill_cmd: state <= l2_cache_pkg::fill_wait;
				l2_cache_pkg::fill_wait: if (mp_done) state <= l2_cache_pkg::install;
				l2_cache_pkg::install: state <= l2_cache_pkg::respond;
				l2_cache_pkg::respond:
					if (!rsp_valid) begin
						rsp_valid <= 1'b1; // Response registered first
					end else if (rsp_ready) begin
						rsp_valid <= 1'b0;
						state <= l2_cache_pkg::idle;
					end
				default: state <= l2_cache_pkg::idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (lookup_en) begin
			req_q <= grant;
			core_q <= grant_core;
		end
		if (state == l2_cache_pkg::lookup)
			miss_q <= !hit;
		if (state == l2_cache_pkg::respond && !rsp_valid) begin
			rsp.core <= core_q;
			rsp.is_store <= req_q.is_store;
			rsp.addr <= req_q.addr;
			if (req_q.is_store)
				rsp.data <= req_q.data; // Echo of the stored line
			else
				rsp.data <= miss_q ? mp_rline : data_rdata;
		end
	end

	// Core side sees a frozen response while it stalls
	a_rsp_stable: assert property (@(posedge clk) disable iff (!arst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));
endmodule

// File: src/l2_cache_data.sv
// Line data array of the L2 cache with one registered read port
`timescale 1ns/1ps

module l2_cache_data (
	input logic clk,
	input logic rd_en,
	input logic wr_en,
	input l2_cache_pkg::l2_set_idx_t set,
	input l2_cache_pkg::l2_way_idx_t way,
	input l2_cache_pkg::cache_line_t wdata,
	output l2_cache_pkg::cache_line_t rdata
);
	// One entry per set and way
	l2_cache_pkg::cache_line_t lines [l2_cache_pkg::l2_sets*l2_cache_pkg::l2_ways];

	always_ff @(posedge clk) begin
		if (wr_en)
			lines[{set, way}] <= wdata;
		if (rd_en)
			rdata <= lines[{set, way}]; // Held until the next read
	end

	// Controller never overlaps a fill write with a victim or hit read
	a_no_rd_wr: assert property (@(posedge clk) !(rd_en && wr_en));
endmodule

// File: src/l2_cache_tag.sv
// Tag store for the L2 cache with hit detection, victim choice and LRU tracking
`timescale 1ns/1ps

module l2_cache_tag (
	input logic clk,
	input logic arst_n,
	input logic lookup_en,
	input l2_cache_pkg::line_addr_t lookup_addr,
	output logic hit,
	output l2_cache_pkg::l2_way_idx_t hit_way,
	output l2_cache_pkg::l2_way_idx_t victim_way,
	output logic victim_dirty,
	output l2_cache_pkg::l2_tag_t victim_tag,
	input logic install_en,
	input l2_cache_pkg::l2_way_idx_t install_way,
	input logic install_dirty,
	input logic touch_en,
	input l2_cache_pkg::l2_way_idx_t touch_way,
	input logic mark_dirty_en
);
	logic [l2_cache_pkg::l2_ways-1:0] valid [l2_cache_pkg::l2_sets];
	logic [l2_cache_pkg::l2_ways-1:0] dirty [l2_cache_pkg::l2_sets];
	l2_cache_pkg::l2_way_idx_t lru [l2_cache_pkg::l2_sets]; // Way to evict next
	l2_cache_pkg::l2_tag_t tag_mem [l2_cache_pkg::l2_sets][l2_cache_pkg::l2_ways];
	l2_cache_pkg::l2_set_idx_t set_q; // Set of the last lookup
	l2_cache_pkg::l2_tag_t tag_q;
	logic [l2_cache_pkg::l2_ways-1:0] match;

	// Results follow the registered lookup address
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < l2_cache_pkg::l2_ways; w++) begin
			match[w] = valid[set_q][w] && tag_mem[set_q][w] == tag_q;
			if (match[w])
				hit_way = l2_cache_pkg::l2_way_idx_t'(w);
		end
		hit = |match;
		victim_way = lru[set_q];
		for (int w = l2_cache_pkg::l2_ways - 1; w >= 0; w--)
			if (!valid[set_q][w])
				victim_way = l2_cache_pkg::l2_way_idx_t'(w); // Lowest free way wins
		victim_dirty = dirty[set_q][victim_way]; // Only valid lines are ever dirty
		victim_tag = tag_mem[set_q][victim_way];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			set_q <= '0;
			tag_q <= '0;
			for (int s = 0; s < l2_cache_pkg::l2_sets; s++) begin
				valid[s] <= '0;
				dirty[s] <= '0;
				lru[s] <= '0;
			end
		end else begin
			if (lookup_en) begin
				set_q <= lookup_addr[l2_cache_pkg::set_bits-1:0];
				tag_q <= lookup_addr[l2_cache_pkg::set_bits +: l2_cache_pkg::tag_bits];
			end
			if (install_en) begin
				valid[set_q][install_way] <= 1'b1;
				dirty[set_q][install_way] <= install_dirty; // Store miss installs dirty
			end
			if (mark_dirty_en)
				dirty[set_q][hit_way] <= 1'b1;
			if (touch_en)
				lru[set_q] <= ~touch_way; // Other way becomes LRU
		end
	end

	always_ff @(posedge clk)
		if (install_en)
			tag_mem[set_q][install_way] <= tag_q;

	a_single_hit: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(match));
endmodule

// File: src/l2_cache_arb.sv
// Round-robin arbiter that hands one core request at a time to the L2 controller
`timescale 1ns/1ps

module l2_cache_arb (
	input logic clk,
	input logic arst_n,
	input logic [l2_cache_pkg::num_cores-1:0] req_valid,
	input l2_cache_pkg::l2_req_t req [l2_cache_pkg::num_cores],
	output logic [l2_cache_pkg::num_cores-1:0] req_ready,
	output logic grant_valid,
	output l2_cache_pkg::l2_req_t grant,
	output l2_cache_pkg::core_id_t grant_core,
	input logic grant_take
);
	l2_cache_pkg::core_id_t prio; // Core favored in the next pick

	always_comb begin
		grant_valid = |req_valid;
		grant_core = prio;
		if (!req_valid[prio])
			grant_core = prio + 1'b1; // Other core when favored one is idle
		grant = req[grant_core];
		req_ready = '0;
		req_ready[grant_core] = grant_valid && grant_take; // Only the winner sees ready
	end

	// Pointer swings away from the core just served
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			prio <= '0;
		else if (grant_valid && grant_take)
			prio <= grant_core + 1'b1;
	end

	// A waiting core keeps its request until it is taken
	for (genvar c = 0; c < l2_cache_pkg::num_cores; c++) begin : g_hold
		a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
			req_valid[c] && !req_ready[c] |=> req_valid[c] && $stable(req[c]));
	end
endmodule

// File: src/l2_cache_pkg.sv
// Shared sizes, types and controller states for the two-core L2 cache
package l2_cache_pkg;
	localparam int num_cores = 2;
	localparam int l2_ways = 2;
	localparam int l2_sets = 16;
	localparam int beat_width = 32;
	localparam int beats_per_line = 4;
	localparam int counter_width = 16;
	localparam int set_bits = $clog2(l2_sets); // Low bits of a line address
	localparam int tag_bits = 8; // High bits of a line address

	typedef logic [$clog2(num_cores)-1:0] core_id_t;
	typedef logic [tag_bits+set_bits-1:0] line_addr_t;
	typedef logic [set_bits-1:0] l2_set_idx_t;
	typedef logic [tag_bits-1:0] l2_tag_t;
	typedef logic [$clog2(l2_ways)-1:0] l2_way_idx_t;
	typedef logic [beat_width-1:0] beat_t;
	typedef logic [beat_width*beats_per_line-1:0] cache_line_t; // Beat 0 in low bits
	typedef logic [counter_width-1:0] perf_count_t;

	// Line-sized request from a core
	typedef struct packed {
		logic is_store;
		line_addr_t addr;
		cache_line_t data; // Store data, ignored on loads
	} l2_req_t;

	// Response back to the requesting core
	typedef struct packed {
		core_id_t core;
		logic is_store;
		line_addr_t addr;
		cache_line_t data; // Load line or echoed store line
	} l2_rsp_t;

	typedef struct packed {
		logic is_write;
		line_addr_t addr;
	} mem_cmd_t;

	typedef enum logic [2:0] {
		idle,
		lookup, // Tag result available
		respond,
		wb_cmd, // Victim line read, start writeback
		wb_wait,
		fill_cmd,
		fill_wait,
		install
	} ctrl_state_t;
endpackage
